// File: logic/texwr_pkg.sv
`default_nettype none

package texwr_pkg;

    // pixel format
    localparam int COMP_NUM = 3;
    localparam int COMP_W = 8;
    localparam int BLK = 4;

    // one beat is one block row of one component
    localparam int AXI_DATA_W = 32;
    localparam int BURST_BEATS = 4;
    localparam int BURST_BYTES = 16;

    // fixed AW fields, incrementing 4 x 32-bit bursts
    localparam logic [7:0] AXI_AWLEN = 8'd3;
    localparam logic [2:0] AXI_AWSIZE = 3'd2;
    localparam logic [1:0] AXI_AWBURST = 2'b01;

    // frame controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_DRAIN,
        ST_FLUSH
    } texwr_state_t;

endpackage

`default_nettype wire

// File: logic/blk_beat_if.sv
`timescale 1ns/1ns
`default_nettype none

interface blk_beat_if #(
    parameter int ADDR_WIDTH = 32
);

    // burst start address, only looked at on the first beat
    logic [ADDR_WIDTH-1:0] addr;
    logic [texwr_pkg::AXI_DATA_W-1:0] data;
    logic last;
    logic valid;
    logic ready;

    // line buffer side
    modport source (
        output addr,
        output data,
        output last,
        output valid,
        input  ready
    );

    // burst writer side
    modport sink (
        input  addr,
        input  data,
        input  last,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// File: logic/texwr_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module texwr_ctrl_fsm (
    input  wire  clk,
    input  wire  reset,
    input  wire  enable,
    output logic busy,
    input  wire  line_full,
    input  wire  block_row_done,
    input  wire  frame_end,
    input  wire  write_idle,
    output logic fill_en,
    output logic drain_en
);

    texwr_pkg::texwr_state_t state;
    texwr_pkg::texwr_state_t state_next;

    // ----------------------------------------
    // next state
    // ----------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            texwr_pkg::ST_IDLE: begin
                if (enable) begin
                    state_next = texwr_pkg::ST_FILL;
                end
            end
            texwr_pkg::ST_FILL: begin
                // fourth line of the block row is in
                if (line_full) begin
                    state_next = texwr_pkg::ST_DRAIN;
                end
            end
            texwr_pkg::ST_DRAIN: begin
                if (block_row_done) begin
                    if (frame_end) begin
                        state_next = texwr_pkg::ST_FLUSH;
                    end else begin
                        state_next = texwr_pkg::ST_FILL;
                    end
                end
            end
            default: begin
                // wait for the last B response
                if (write_idle) begin
                    state_next = texwr_pkg::ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= texwr_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign busy = (state != texwr_pkg::ST_IDLE);
    assign fill_en = (state == texwr_pkg::ST_FILL);
    assign drain_en = (state == texwr_pkg::ST_DRAIN);

endmodule

`default_nettype wire

// File: logic/blk_scan_counter.sv
`timescale 1ns/1ns
`default_nettype none

module blk_scan_counter #(
    parameter int X_WIDTH = 10,
    parameter int Y_WIDTH = 10,
    parameter int ADDR_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire  [ADDR_WIDTH-1:0] param_addr,
    input  wire  [X_WIDTH-1:0]    param_width,
    input  wire  [Y_WIDTH-1:0]    param_height,
    input  wire                   fill_en,
    input  wire                   drain_en,
    input  wire                   pix_fire,
    input  wire                   beat_fire,
    output logic [X_WIDTH-1:0]    wr_x,
    output logic [1:0]            wr_row,
    output logic [X_WIDTH-3:0]    rd_blk_x,
    output logic [1:0]            rd_comp,
    output logic [1:0]            rd_row,
    output logic [ADDR_WIDTH-1:0] burst_addr,
    output logic                  line_full,
    output logic                  block_row_done,
    output logic                  frame_end
);

    logic [X_WIDTH-3:0] blks_per_row;
    logic [Y_WIDTH-3:0] blk_row;
    // blk_row * blks_per_row, kept as a running sum
    logic [ADDR_WIDTH-1:0] row_blk_base;
    logic pix_step;
    logic beat_step;
    logic x_last;
    logic row_end;
    logic comp_end;
    logic bx_end;

    assign blks_per_row = param_width[X_WIDTH-1:2];
    assign pix_step = fill_en && pix_fire;
    assign beat_step = drain_en && beat_fire;

    assign x_last = (wr_x == param_width - 1'b1);
    assign row_end = (rd_row == 2'(texwr_pkg::BURST_BEATS - 1));
    assign comp_end = (rd_comp == 2'(texwr_pkg::COMP_NUM - 1));
    assign bx_end = (rd_blk_x == blks_per_row - 1'b1);

    assign line_full = pix_step && x_last && (wr_row == 2'(texwr_pkg::BLK - 1));
    assign block_row_done = beat_step && row_end && comp_end && bx_end;
    assign frame_end = (blk_row == param_height[Y_WIDTH-1:2] - 1'b1);

    // base + (block index * 3 + component) * 16
    assign burst_addr = param_addr
        + ((row_blk_base + ADDR_WIDTH'(rd_blk_x)) * ADDR_WIDTH'(texwr_pkg::COMP_NUM)
        + ADDR_WIDTH'(rd_comp)) * ADDR_WIDTH'(texwr_pkg::BURST_BYTES);

    // ----------------------------------------
    // raster write position
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_x <= '0;
            wr_row <= '0;
        end else if (pix_step) begin
            if (x_last) begin
                wr_x <= '0;
                wr_row <= wr_row + 2'd1;
            end else begin
                wr_x <= wr_x + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // block read position
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_row <= '0;
            rd_comp <= '0;
            rd_blk_x <= '0;
        end else if (beat_step) begin
            rd_row <= rd_row + 2'd1;
            if (row_end) begin
                if (comp_end) begin
                    rd_comp <= '0;
                    rd_blk_x <= bx_end ? '0 : rd_blk_x + 1'b1;
                end else begin
                    rd_comp <= rd_comp + 2'd1;
                end
            end
        end
    end

    // block row index, back to zero after the last one
    always_ff @(posedge clk) begin
        if (reset) begin
            blk_row <= '0;
            row_blk_base <= '0;
        end else if (block_row_done) begin
            if (frame_end) begin
                blk_row <= '0;
                row_blk_base <= '0;
            end else begin
                blk_row <= blk_row + 1'b1;
                row_blk_base <= row_blk_base + ADDR_WIDTH'(blks_per_row);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/line_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module line_buffer #(
    parameter int X_WIDTH = 10,
    parameter int ADDR_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   fill_en,
    input  wire                   drain_en,
    input  wire  [texwr_pkg::COMP_NUM*texwr_pkg::COMP_W-1:0] s_tdata,
    input  wire                   s_tvalid,
    output logic                  s_tready,
    output logic                  pix_fire,
    input  wire  [X_WIDTH-1:0]    wr_x,
    input  wire  [1:0]            wr_row,
    input  wire  [X_WIDTH-3:0]    rd_blk_x,
    input  wire  [1:0]            rd_comp,
    input  wire  [1:0]            rd_row,
    input  wire  [ADDR_WIDTH-1:0] burst_addr,
    output logic                  beat_fire,
    blk_beat_if.source            beat
);

    // one word holds four adjacent pixels of one line, component planes side by side
    localparam int QUAD_W = texwr_pkg::COMP_NUM * texwr_pkg::AXI_DATA_W;
    localparam int DEPTH = 1 << X_WIDTH;

    logic [QUAD_W-1:0] mem [DEPTH];
    logic [X_WIDTH-1:0] wr_idx;
    logic [X_WIDTH-1:0] rd_idx;
    logic [QUAD_W-1:0] rd_word;
    logic load;

    assign wr_idx = {wr_row, wr_x[X_WIDTH-1:2]};
    assign rd_idx = {rd_row, rd_blk_x};

    assign s_tready = fill_en;
    assign pix_fire = s_tvalid && s_tready;
    assign beat_fire = beat.valid && beat.ready;

    // ----------------------------------------
    // pixel write, byte lanes per component
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (pix_fire) begin
            for (int c = 0; c < texwr_pkg::COMP_NUM; c++) begin
                mem[wr_idx][(c * texwr_pkg::BLK + wr_x[1:0]) * texwr_pkg::COMP_W
                    +: texwr_pkg::COMP_W] <= s_tdata[c * texwr_pkg::COMP_W +: texwr_pkg::COMP_W];
            end
        end
    end

    // ----------------------------------------
    // beat register
    // ----------------------------------------
    assign rd_word = mem[rd_idx];
    // fetch whenever the register is empty in drain
    assign load = drain_en && !beat.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            beat.valid <= 1'b0;
        end else if (beat_fire) begin
            beat.valid <= 1'b0;
        end else if (load) begin
            beat.valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            beat.data <= rd_word[rd_comp * texwr_pkg::AXI_DATA_W +: texwr_pkg::AXI_DATA_W];
            beat.last <= (rd_row == 2'(texwr_pkg::BURST_BEATS - 1));
            beat.addr <= burst_addr;
        end
    end

endmodule

`default_nettype wire

// File: logic/axi4_burst_writer.sv
`timescale 1ns/1ns
`default_nettype none

module axi4_burst_writer #(
    parameter int ADDR_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   reset,
    blk_beat_if.sink              beat,
    output logic [ADDR_WIDTH-1:0] awaddr,
    output logic [7:0]            awlen,
    output logic [2:0]            awsize,
    output logic [1:0]            awburst,
    output logic                  awvalid,
    input  wire                   awready,
    output logic [texwr_pkg::AXI_DATA_W-1:0]   wdata,
    output logic [texwr_pkg::AXI_DATA_W/8-1:0] wstrb,
    output logic                  wlast,
    output logic                  wvalid,
    input  wire                   wready,
    input  wire  [1:0]            bresp,
    input  wire                   bvalid,
    output logic                  bready,
    output logic                  write_idle
);

    localparam int OUTS_W = 8;

    logic [OUTS_W-1:0] outstanding;
    logic first_beat;
    logic take;
    logic aw_fire;
    logic b_fire;

    assign aw_fire = awvalid && awready;
    assign b_fire = bvalid && bready;

    // stall on either channel, or once half the response window is in use
    assign beat.ready = (!wvalid || wready) && (!awvalid || awready)
        && !outstanding[OUTS_W-1];
    assign take = beat.valid && beat.ready;

    assign awlen = texwr_pkg::AXI_AWLEN;
    assign awsize = texwr_pkg::AXI_AWSIZE;
    assign awburst = texwr_pkg::AXI_AWBURST;
    assign wstrb = '1;
    // responses are only counted
    assign bready = 1'b1;

    assign write_idle = (outstanding == '0) && !awvalid && !wvalid;

    // ----------------------------------------
    // AW channel
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            awvalid <= 1'b0;
            first_beat <= 1'b1;
        end else begin
            if (take && first_beat) begin
                awvalid <= 1'b1;
            end else if (awready) begin
                awvalid <= 1'b0;
            end
            if (take) begin
                first_beat <= beat.last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && first_beat) begin
            awaddr <= beat.addr;
        end
    end

    // ----------------------------------------
    // W channel
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wvalid <= 1'b0;
        end else if (take) begin
            wvalid <= 1'b1;
        end else if (wready) begin
            wvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wdata <= beat.data;
            wlast <= beat.last;
        end
    end

    // bursts between AW and B
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + OUTS_W'(aw_fire) - OUTS_W'(b_fire);
        end
    end

endmodule

`default_nettype wire

// File: logic/texture_writer.sv
`timescale 1ns/1ns
`default_nettype none

module texture_writer #(
    parameter int X_WIDTH = 10,
    parameter int Y_WIDTH = 10,
    parameter int ADDR_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   enable,
    output logic                  busy,
    input  wire  [ADDR_WIDTH-1:0] param_addr,
    input  wire  [X_WIDTH-1:0]    param_width,
    input  wire  [Y_WIDTH-1:0]    param_height,
    input  wire  [texwr_pkg::COMP_NUM*texwr_pkg::COMP_W-1:0] s_tdata,
    input  wire                   s_tuser,
    input  wire                   s_tvalid,
    output logic                  s_tready,
    output logic [ADDR_WIDTH-1:0] awaddr,
    output logic [7:0]            awlen,
    output logic [2:0]            awsize,
    output logic [1:0]            awburst,
    output logic                  awvalid,
    input  wire                   awready,
    output logic [texwr_pkg::AXI_DATA_W-1:0]   wdata,
    output logic [texwr_pkg::AXI_DATA_W/8-1:0] wstrb,
    output logic                  wlast,
    output logic                  wvalid,
    input  wire                   wready,
    input  wire  [1:0]            bresp,
    input  wire                   bvalid,
    output logic                  bready
);

    logic fill_en;
    logic drain_en;
    logic line_full;
    logic block_row_done;
    logic frame_end;
    logic write_idle;
    logic pix_fire;
    logic beat_fire;
    logic [X_WIDTH-1:0] wr_x;
    logic [1:0] wr_row;
    logic [X_WIDTH-3:0] rd_blk_x;
    logic [1:0] rd_comp;
    logic [1:0] rd_row;
    logic [ADDR_WIDTH-1:0] burst_addr;

    blk_beat_if #(.ADDR_WIDTH(ADDR_WIDTH)) beat_if ();

    texwr_ctrl_fsm ctrl_fsm_i (
        .clk            (clk),
        .reset          (reset),
        .enable         (enable),
        .busy           (busy),
        .line_full      (line_full),
        .block_row_done (block_row_done),
        .frame_end      (frame_end),
        .write_idle     (write_idle),
        .fill_en        (fill_en),
        .drain_en       (drain_en)
    );

    blk_scan_counter #(
        .X_WIDTH    (X_WIDTH),
        .Y_WIDTH    (Y_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) scan_counter_i (
        .clk            (clk),
        .reset          (reset),
        .param_addr     (param_addr),
        .param_width    (param_width),
        .param_height   (param_height),
        .fill_en        (fill_en),
        .drain_en       (drain_en),
        .pix_fire       (pix_fire),
        .beat_fire      (beat_fire),
        .wr_x           (wr_x),
        .wr_row         (wr_row),
        .rd_blk_x       (rd_blk_x),
        .rd_comp        (rd_comp),
        .rd_row         (rd_row),
        .burst_addr     (burst_addr),
        .line_full      (line_full),
        .block_row_done (block_row_done),
        .frame_end      (frame_end)
    );

    line_buffer #(
        .X_WIDTH    (X_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) line_buffer_i (
        .clk        (clk),
        .reset      (reset),
        .fill_en    (fill_en),
        .drain_en   (drain_en),
        .s_tdata    (s_tdata),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .pix_fire   (pix_fire),
        .wr_x       (wr_x),
        .wr_row     (wr_row),
        .rd_blk_x   (rd_blk_x),
        .rd_comp    (rd_comp),
        .rd_row     (rd_row),
        .burst_addr (burst_addr),
        .beat_fire  (beat_fire),
        .beat       (beat_if.source)
    );

    axi4_burst_writer #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) burst_writer_i (
        .clk        (clk),
        .reset      (reset),
        .beat       (beat_if.sink),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awsize     (awsize),
        .awburst    (awburst),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .write_idle (write_idle)
    );

endmodule

`default_nettype wire

// File: tb/axi4_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module axi4_mem_model #(
    parameter int ADDR_WIDTH = 32,
    parameter int MEM_BYTES = 65536
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire  [ADDR_WIDTH-1:0] awaddr,
    input  wire  [7:0]            awlen,
    input  wire                   awvalid,
    output logic                  awready,
    input  wire  [31:0]           wdata,
    input  wire  [3:0]            wstrb,
    input  wire                   wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  wire                   bready
);

    logic [7:0] mem [MEM_BYTES];

    // bursts and beats wait here until both halves are known
    logic [ADDR_WIDTH-1:0] aw_q [$];
    int len_q [$];
    logic [31:0] w_q [$];
    logic [3:0] strb_q [$];

    integer seed;
    int beat_idx;
    int b_pending;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0] wr_strb;

    initial begin
        seed = 60604;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = 2'b00;
        beat_idx = 0;
        b_pending = 0;
        // fill pattern over the whole address
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'(i ^ (i >> 8));
        end
    end

    // ----------------------------------------
    // ready stalls and responses
    // ----------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            awready = 1'b0;
            wready = 1'b0;
            bvalid = 1'b0;
        end else begin
            // each channel stalls about a quarter of the time
            awready = ($random(seed) & 3) != 0;
            wready = ($random(seed) & 3) != 0;
            bvalid = (b_pending > 0) && (($random(seed) & 1) != 0);
        end
    end

    // ----------------------------------------
    // handshakes and byte writes
    // ----------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            aw_q.delete();
            len_q.delete();
            w_q.delete();
            strb_q.delete();
            beat_idx = 0;
            b_pending = 0;
        end else begin
            if (bvalid && bready) begin
                b_pending--;
            end
            if (awvalid && awready) begin
                aw_q.push_back(awaddr);
                len_q.push_back(int'(awlen) + 1);
            end
            if (wvalid && wready) begin
                w_q.push_back(wdata);
                strb_q.push_back(wstrb);
            end
            // W may run ahead of its AW
            while (aw_q.size() > 0 && w_q.size() > 0) begin
                wr_addr = aw_q[0] + beat_idx * 4;
                wr_data = w_q.pop_front();
                wr_strb = strb_q.pop_front();
                for (int k = 0; k < 4; k++) begin
                    if (wr_strb[k]) begin
                        mem[(wr_addr + k) % MEM_BYTES] = wr_data[k * 8 +: 8];
                    end
                end
                beat_idx++;
                if (beat_idx == len_q[0]) begin
                    beat_idx = 0;
                    void'(aw_q.pop_front());
                    void'(len_q.pop_front());
                    b_pending++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/texture_writer_tb.sv
`timescale 1ns/1ns
`default_nettype none

module texture_writer_tb;

    localparam int X_WIDTH = 10;
    localparam int Y_WIDTH = 10;
    localparam int ADDR_WIDTH = 32;
    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int MEM_BYTES = 65536;

    // two frames, back to back
    localparam logic [31:0] F0_BASE = 32'h0000_1000;
    localparam int F0_W = 16;
    localparam int F0_H = 8;
    localparam logic [31:0] F1_BASE = 32'h0000_4000;
    localparam int F1_W = 24;
    localparam int F1_H = 12;

    // pixels plus W beats of both frames
    localparam int WORK = F0_W * F0_H + F0_W * F0_H * 3 / 4
        + F1_W * F1_H + F1_W * F1_H * 3 / 4;
    localparam int TIMEOUT_CYCLES = 10 * WORK + RESET_CYCLES;

    logic clk;
    logic reset;
    logic enable;
    logic busy;
    logic [ADDR_WIDTH-1:0] param_addr;
    logic [X_WIDTH-1:0] param_width;
    logic [Y_WIDTH-1:0] param_height;
    logic [23:0] s_tdata;
    logic s_tuser;
    logic s_tvalid;
    logic s_tready;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wlast;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;

    integer seed;
    logic [23:0] img [4096];
    logic [31:0] cur_base;
    int cur_width;
    int cur_height;
    int cur_bursts;
    int aw_count;
    int w_count;
    int b_count;
    logic busy_prev;
    int err_aw;
    int err_w;
    int err_count;
    int err_mem;
    int err_busy;
    int err_reset;

    texture_writer #(
        .X_WIDTH    (X_WIDTH),
        .Y_WIDTH    (Y_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) texture_writer_i (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .busy         (busy),
        .param_addr   (param_addr),
        .param_width  (param_width),
        .param_height (param_height),
        .s_tdata      (s_tdata),
        .s_tuser      (s_tuser),
        .s_tvalid     (s_tvalid),
        .s_tready     (s_tready),
        .awaddr       (awaddr),
        .awlen        (awlen),
        .awsize       (awsize),
        .awburst      (awburst),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wlast        (wlast),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready)
    );

    axi4_mem_model #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .MEM_BYTES  (MEM_BYTES)
    ) mem_model_i (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // bursts go block row, block column, component
    function automatic logic [31:0] burst_address(input int burst);
        int blk;
        int comp;
        int bpr;
        bpr = cur_width / 4;
        blk = burst / 3;
        comp = burst % 3;
        return cur_base + (((blk / bpr) * bpr + blk % bpr) * 3 + comp) * 16;
    endfunction

    // four pixels of one block row, leftmost in the low byte
    function automatic logic [31:0] beat_data(input int idx);
        int blk;
        int comp;
        int row;
        int bpr;
        logic [23:0] pix;
        logic [31:0] data;
        bpr = cur_width / 4;
        blk = (idx / 4) / 3;
        comp = (idx / 4) % 3;
        row = idx % 4;
        data = '0;
        for (int k = 0; k < 4; k++) begin
            pix = img[((blk / bpr) * 4 + row) * cur_width + (blk % bpr) * 4 + k];
            data[k * 8 +: 8] = pix[comp * 8 +: 8];
        end
        return data;
    endfunction

    // ----------------------------------------
    // AXI monitor
    // ----------------------------------------
    always @(posedge clk) begin
        if (!reset) begin
            // falling busy, sampled before this edge's B is counted
            if (busy_prev && !busy) begin
                assert (b_count == cur_bursts && aw_count == b_count) else begin
                    err_busy++;
                    $display("Fail %0t: busy fell with %0d AW and %0d B, expected %0d",
                        $time, aw_count, b_count, cur_bursts);
                end
            end
            if (awvalid && awready) begin
                assert (awlen == 8'd3 && awsize == 3'd2 && awburst == 2'b01) else begin
                    err_aw++;
                    $display("Fail %0t: AW len %0d size %0d burst %0d", $time,
                        awlen, awsize, awburst);
                end
                assert (awaddr == burst_address(aw_count)) else begin
                    err_aw++;
                    $display("Fail %0t: awaddr %h, expected %h", $time, awaddr,
                        burst_address(aw_count));
                end
                aw_count++;
            end
            if (wvalid && wready) begin
                assert (wdata == beat_data(w_count)) else begin
                    err_w++;
                    $display("Fail %0t: beat %0d wdata %h, expected %h", $time, w_count,
                        wdata, beat_data(w_count));
                end
                assert (wstrb == 4'hf) else begin
                    err_w++;
                    $display("Fail %0t: wstrb %h, expected f", $time, wstrb);
                end
                assert (wlast == ((w_count % 4) == 3)) else begin
                    err_w++;
                    $display("Fail %0t: wlast %b on beat %0d", $time, wlast, w_count);
                end
                w_count++;
            end
            if (bvalid && bready) begin
                b_count++;
            end
            busy_prev = busy;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    // called on a falling edge, ready holds through the next rising edge
    task automatic send_pixel(input logic [23:0] pix, input logic first);
        s_tdata = pix;
        s_tuser = first;
        s_tvalid = 1'b1;
        while (!s_tready) begin
            @(negedge clk);
        end
        @(negedge clk);
        s_tvalid = 1'b0;
        s_tuser = 1'b0;
    endtask

    task automatic check_memory();
        int addr;
        logic [23:0] pix;
        logic [7:0] got;
        for (int y = 0; y < cur_height; y++) begin
            for (int x = 0; x < cur_width; x++) begin
                pix = img[y * cur_width + x];
                for (int c = 0; c < 3; c++) begin
                    addr = cur_base + (((y / 4) * (cur_width / 4) + x / 4) * 3 + c) * 16
                        + (y % 4) * 4 + x % 4;
                    got = mem_model_i.mem[addr % MEM_BYTES];
                    assert (got == pix[c * 8 +: 8]) else begin
                        err_mem++;
                        $display("Fail %0t: byte at %h is %h, expected %h", $time, addr,
                            got, pix[c * 8 +: 8]);
                    end
                end
            end
        end
    endtask

    task automatic run_frame(input logic [31:0] base, input int width, input int height);
        @(negedge clk);
        cur_base = base;
        cur_width = width;
        cur_height = height;
        cur_bursts = width * height * 3 / 16;
        param_addr = base;
        param_width = X_WIDTH'(width);
        param_height = Y_WIDTH'(height);
        aw_count = 0;
        w_count = 0;
        b_count = 0;
        for (int i = 0; i < width * height; i++) begin
            img[i] = 24'($random(seed));
        end
        assert (!busy) else begin
            err_busy++;
            $display("Fail %0t: busy high before enable", $time);
        end
        enable = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        assert (busy) else begin
            err_busy++;
            $display("Fail %0t: busy low the cycle after enable", $time);
        end
        for (int y = 0; y < height; y++) begin
            for (int x = 0; x < width; x++) begin
                // random gaps on the pixel stream
                while (($random(seed) & 3) == 0) begin
                    @(negedge clk);
                end
                send_pixel(img[y * width + x], (x == 0 && y == 0));
            end
        end
        while (busy) begin
            @(negedge clk);
        end
        assert (aw_count == cur_bursts) else begin
            err_count++;
            $display("Fail %0t: %0d AW handshakes, expected %0d", $time, aw_count, cur_bursts);
        end
        assert (w_count == cur_bursts * 4) else begin
            err_count++;
            $display("Fail %0t: %0d W beats, expected %0d", $time, w_count, cur_bursts * 4);
        end
        assert (b_count == cur_bursts) else begin
            err_count++;
            $display("Fail %0t: %0d B handshakes, expected %0d", $time, b_count, cur_bursts);
        end
        check_memory();
    endtask

    initial begin
        seed = 60604;
        clk = 1'b0;
        reset = 1'b1;
        enable = 1'b0;
        param_addr = '0;
        param_width = '0;
        param_height = '0;
        s_tdata = '0;
        s_tuser = 1'b0;
        s_tvalid = 1'b0;
        cur_base = '0;
        cur_width = 4;
        cur_height = 4;
        cur_bursts = 0;
        aw_count = 0;
        w_count = 0;
        b_count = 0;
        busy_prev = 1'b0;
        err_aw = 0;
        err_w = 0;
        err_count = 0;
        err_mem = 0;
        err_busy = 0;
        err_reset = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
        end
        reset = 1'b0;
        assert (!busy) else begin
            err_busy++;
            $display("Fail %0t: busy high after reset", $time);
        end
        // handshake outputs in their idle levels
        assert (!s_tready && !awvalid && !wvalid && bready) else begin
            err_reset++;
            $display("Fail %0t: after reset s_tready %b awvalid %b wvalid %b bready %b",
                $time, s_tready, awvalid, wvalid, bready);
        end
        run_frame(F0_BASE, F0_W, F0_H);
        run_frame(F1_BASE, F1_W, F1_H);
        @(negedge clk);
        @(negedge clk);
        $display("errors: aw %0d, w %0d, count %0d, mem %0d, busy %0d, reset %0d",
            err_aw, err_w, err_count, err_mem, err_busy, err_reset);
        if (err_aw + err_w + err_count + err_mem + err_busy + err_reset == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
logic/texwr_pkg.sv
logic/blk_beat_if.sv
logic/texwr_ctrl_fsm.sv
logic/blk_scan_counter.sv
logic/line_buffer.sv
logic/axi4_burst_writer.sv
logic/texture_writer.sv
tb/axi4_mem_model.sv
tb/texture_writer_tb.sv
